// ==== all.f ====
core_pkg.sv
fetch_unit.sv
decoder.sv
register_file.sv
hazard_unit.sv
execute_unit.sv
core_top.sv
tb_core.sv

// ==== core_golden.txt ====
// Hex words for $readmemh. Header: program words, seed pairs, expected store pairs
// Seed and expected sections hold address then value, one pair per line
@000
00000046 00000002 0000001D
// Program, x1 = 0x123, x2 = -6, x3 = 0x80001000
@010
12300093 FFA00113 800011B7
00208233 20402023    // add, forwarded from writeback, memory and execute
402082B3 20502223    // sub
0020F333 20602423    // and
0020E3B3 20702623    // or
0020C433 20802823    // xor
001124B3 20902A23    // slt x2 < x1
00113533 20A02C23    // sltu x2 < x1
00400593             // x11 = 4, shift amount
00B09633 20C02E23    // sll
00B1D6B3 22D02023    // srl
40B1D733 22E02223    // sra
22302423             // store lui result
0F017793 22F02623    // andi
7000E793 22F02823    // ori
FFF0C793 22F02A23    // xori
FFB12793 22F02C23    // slti
00513793 22F02E23    // sltiu
00809793 24F02023    // slli
00C1D793 24F02223    // srli
40C1D793 24F02423    // srai
00700813 00380813 010808B3 00100913 010889B3 25302623 25202823
10002A83 001A8B33 25602A23    // load then add right away
10402B83 25702C23             // load then store it right away
00108663 40102023 40202223    // beq taken, both stores skipped
00209663 40102423 40202623    // bne taken, both stores skipped
00208663 24102E23 26202023    // beq not taken
01081663 27002223 27102423    // bne not taken
00508013 26002623             // write to x0, then store x0
5A500A13 7F402E23 00000063    // end marker store, then spin
// Data seeds
@0E0
00000100 00001000
00000104 13579BDF
// Expected stores in order
@100
00000200 0000011D
00000204 00000129
00000208 00000122
0000020C FFFFFFFB
00000210 FFFFFED9
00000214 00000001
00000218 00000000
0000021C 00001230
00000220 08000100
00000224 F8000100
00000228 80001000
0000022C 000000F0
00000230 00000723
00000234 FFFFFEDC
00000238 00000001
0000023C 00000000
00000240 00012300
00000244 00080001
00000248 FFF80001
0000024C 0000001E
00000250 00000001
00000254 00001123
00000258 13579BDF
0000025C 00000123
00000260 FFFFFFFA
00000264 0000000A
00000268 00000014
0000026C 00000000
000007FC 000005A5

// ==== core_pkg.sv ====
package core_pkg;

    // ------------------------------
    // Widths and constants
    // ------------------------------
    localparam int XLEN            = 32;
    localparam int REG_COUNT       = 32;
    localparam int REG_INDEX_WIDTH = 5;

    localparam logic [XLEN-1:0] RESET_ADDRESS = 32'h0000_0000;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    typedef logic [XLEN-1:0]            word_t;
    typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;

    // ------------------------------
    // Opcodes and ALU operations
    // ------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // ------------------------------
    // Stage payloads
    // ------------------------------
    typedef struct packed {
        opcode_e    opcode;
        alu_op_e    alu_op;
        reg_index_t rs1_index;
        reg_index_t rs2_index;
        reg_index_t rd_index;
        logic       read_enable_1;
        logic       read_enable_2;
        logic       write_enable;
        logic       use_immediate;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       branch_on_equal;
        word_t      immediate;
    } decode_t;

    typedef struct packed {
        decode_t decoded;
        word_t   pc;
        word_t   rs1_value;
        word_t   rs2_value;
    } id_ex_t;

    // result is the ALU output, or the address for loads and stores
    typedef struct packed {
        reg_index_t rd_index;
        logic       write_enable;
        logic       is_load;
        logic       is_store;
        word_t      result;
        word_t      store_data;
    } ex_mem_t;

    typedef struct packed {
        reg_index_t rd_index;
        logic       write_enable;
        word_t      write_data;
    } mem_wb_t;

endpackage

// ==== core_top.sv ====
module core_top
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output word_t imem_addr,
    input  word_t imem_data,
    output logic  dmem_enable,
    output logic  dmem_write,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    input  word_t dmem_rdata
);

    word_t   pc;
    logic    stall;
    logic    branch_taken;
    word_t   branch_target;
    word_t   if_id_instruction;
    word_t   if_id_pc;
    decode_t decoded;
    word_t   file_data_1;
    word_t   file_data_2;
    word_t   rs1_value;
    word_t   rs2_value;
    id_ex_t  id_ex;
    word_t   ex_result;
    ex_mem_t ex_mem;
    word_t   mem_write_data;
    mem_wb_t mem_wb;

    // ------------------------------
    // Fetch
    // ------------------------------
    fetch_unit u_fetch (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    assign imem_addr = pc;

    // IF/ID, a flush turns the slot into a NOP
    always_ff @(posedge clk)
    begin
        if (reset || branch_taken)
            if_id_instruction <= NOP_WORD;
        else if (!stall)
            if_id_instruction <= imem_data;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
            if_id_pc <= pc;
    end

    // ------------------------------
    // Decode
    // ------------------------------
    decoder u_decoder (
        .instruction (if_id_instruction),
        .decoded     (decoded)
    );

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (decoded.rs1_index),
        .read_index_2 (decoded.rs2_index),
        .read_data_1  (file_data_1),
        .read_data_2  (file_data_2),
        .write_enable (mem_wb.write_enable),
        .write_index  (mem_wb.rd_index),
        .write_data   (mem_wb.write_data)
    );

    hazard_unit u_hazard (
        .decoded       (decoded),
        .ex_stage      (id_ex),
        .ex_result     (ex_result),
        .mem_stage     (ex_mem),
        .mem_load_data (dmem_rdata),
        .wb_stage      (mem_wb),
        .file_data_1   (file_data_1),
        .file_data_2   (file_data_2),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .stall         (stall)
    );

    // ID/EX takes a bubble on stall or flush
    always_ff @(posedge clk)
    begin
        if (reset || branch_taken || stall)
        begin
            id_ex.decoded.write_enable <= 1'b0;
            id_ex.decoded.is_load      <= 1'b0;
            id_ex.decoded.is_store     <= 1'b0;
            id_ex.decoded.is_branch    <= 1'b0;
        end
        else
        begin
            id_ex.decoded   <= decoded;
            id_ex.pc        <= if_id_pc;
            id_ex.rs1_value <= rs1_value;
            id_ex.rs2_value <= rs2_value;
        end
    end

    // ------------------------------
    // Execute
    // ------------------------------
    execute_unit u_execute (
        .ex_stage      (id_ex),
        .result        (ex_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_mem.write_enable <= 1'b0;
            ex_mem.is_load      <= 1'b0;
            ex_mem.is_store     <= 1'b0;
        end
        else
        begin
            ex_mem.rd_index     <= id_ex.decoded.rd_index;
            ex_mem.write_enable <= id_ex.decoded.write_enable;
            ex_mem.is_load      <= id_ex.decoded.is_load;
            ex_mem.is_store     <= id_ex.decoded.is_store;
            ex_mem.result       <= ex_result;
            ex_mem.store_data   <= id_ex.rs2_value;
        end
    end

    // ------------------------------
    // Memory and writeback
    // ------------------------------
    assign dmem_enable = ex_mem.is_load || ex_mem.is_store;
    assign dmem_write  = ex_mem.is_store;
    assign dmem_addr   = ex_mem.result;
    assign dmem_wdata  = ex_mem.store_data;

    assign mem_write_data = ex_mem.is_load ? dmem_rdata : ex_mem.result;

    always_ff @(posedge clk)
    begin
        if (reset)
            mem_wb.write_enable <= 1'b0;
        else
        begin
            mem_wb.rd_index     <= ex_mem.rd_index;
            mem_wb.write_enable <= ex_mem.write_enable;
            mem_wb.write_data   <= mem_write_data;
        end
    end

endmodule

// ==== decoder.sv ====
module decoder
    import core_pkg::*;
(
    input  word_t   instruction,
    output decode_t decoded
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;

    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign rd     = instruction[11:7];

    // ------------------------------
    // Immediate formats
    // ------------------------------
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};

    // alt selects SUB and SRA
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb
    begin
        // Defaults describe a NOP
        decoded.opcode          = OP_IMM;
        decoded.alu_op          = ALU_ADD;
        decoded.rs1_index       = rs1;
        decoded.rs2_index       = rs2;
        decoded.rd_index        = rd;
        decoded.read_enable_1   = 1'b0;
        decoded.read_enable_2   = 1'b0;
        decoded.write_enable    = 1'b0;
        decoded.use_immediate   = 1'b0;
        decoded.branch_on_equal = ~funct3[0];
        decoded.immediate       = '0;

        case (instruction[6:0])
            OP:
            begin
                decoded.opcode        = OP;
                decoded.alu_op        = funct_to_alu(funct3, funct7[5]);
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.write_enable  = 1'b1;
            end
            OP_IMM:
            begin
                // No SUBI, so bit 30 only matters for shifts
                decoded.alu_op        = funct_to_alu(funct3, funct3 == 3'b101 && funct7[5]);
                decoded.read_enable_1 = 1'b1;
                decoded.write_enable  = 1'b1;
                decoded.use_immediate = 1'b1;
                decoded.immediate     = imm_i;
            end
            LUI:
            begin
                decoded.opcode        = LUI;
                decoded.alu_op        = ALU_PASS_B;
                decoded.write_enable  = 1'b1;
                decoded.use_immediate = 1'b1;
                decoded.immediate     = imm_u;
            end
            LOAD:
            begin
                decoded.opcode        = LOAD;
                decoded.read_enable_1 = 1'b1;
                decoded.write_enable  = 1'b1;
                decoded.use_immediate = 1'b1;
                decoded.immediate     = imm_i;
            end
            STORE:
            begin
                decoded.opcode        = STORE;
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.use_immediate = 1'b1;
                decoded.immediate     = imm_s;
            end
            BRANCH:
            begin
                decoded.opcode        = BRANCH;
                decoded.alu_op        = ALU_SUB;
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.immediate     = imm_b;
            end
            default: ;
        endcase

        decoded.is_load   = decoded.opcode == LOAD;
        decoded.is_store  = decoded.opcode == STORE;
        decoded.is_branch = decoded.opcode == BRANCH;

        // x0 is never written
        if (rd == '0)
            decoded.write_enable = 1'b0;
    end

endmodule

// ==== execute_unit.sv ====
module execute_unit
    import core_pkg::*;
(
    input  id_ex_t ex_stage,
    output word_t  result,
    output logic   branch_taken,
    output word_t  branch_target
);

    word_t      operand_a;
    word_t      operand_b;
    logic [4:0] shift_amount;
    logic       operands_equal;

    assign operand_a    = ex_stage.rs1_value;
    assign operand_b    = ex_stage.decoded.use_immediate ? ex_stage.decoded.immediate
                                                         : ex_stage.rs2_value;
    assign shift_amount = operand_b[4:0];

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb
    begin
        case (ex_stage.decoded.alu_op)
            ALU_ADD:
                result = operand_a + operand_b;
            ALU_SUB:
                result = operand_a - operand_b;
            ALU_AND:
                result = operand_a & operand_b;
            ALU_OR:
                result = operand_a | operand_b;
            ALU_XOR:
                result = operand_a ^ operand_b;
            ALU_SLT:
                result = {{(XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU:
                result = {{(XLEN-1){1'b0}}, operand_a < operand_b};
            ALU_SLL:
                result = operand_a << shift_amount;
            ALU_SRL:
                result = operand_a >> shift_amount;
            ALU_SRA:
                result = $signed(operand_a) >>> shift_amount;
            default:
                // LUI passes the upper immediate through
                result = operand_b;
        endcase
    end

    // ------------------------------
    // Branch decision
    // ------------------------------
    assign operands_equal = ex_stage.rs1_value == ex_stage.rs2_value;
    assign branch_taken   = ex_stage.decoded.is_branch
                            && (operands_equal == ex_stage.decoded.branch_on_equal);
    assign branch_target  = ex_stage.pc + ex_stage.decoded.immediate;

endmodule

// ==== fetch_unit.sv ====
module fetch_unit
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t pc
);

    // Redirect wins over the load-use hold
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= RESET_ADDRESS;
        else if (branch_taken)
            pc <= branch_target;
        else if (!stall)
            pc <= pc + 32'd4;
    end

    // Branch targets come from execute, so this also covers the offset path
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// ==== hazard_unit.sv ====
module hazard_unit
    import core_pkg::*;
(
    input  decode_t decoded,
    input  id_ex_t  ex_stage,
    input  word_t   ex_result,
    input  ex_mem_t mem_stage,
    input  word_t   mem_load_data,
    input  mem_wb_t wb_stage,
    input  word_t   file_data_1,
    input  word_t   file_data_2,
    output word_t   rs1_value,
    output word_t   rs2_value,
    output logic    stall
);

    word_t mem_value;
    logic  ex_hit_1;
    logic  ex_hit_2;
    logic  mem_hit_1;
    logic  mem_hit_2;
    logic  wb_hit_1;
    logic  wb_hit_2;

    // A writer matches a source only if the source is really read and not x0
    function automatic logic hits(input reg_index_t rd, input logic we,
                                  input reg_index_t index, input logic read_enable);
        return we && read_enable && index != '0 && rd == index;
    endfunction

    assign mem_value = mem_stage.is_load ? mem_load_data : mem_stage.result;

    // ------------------------------
    // Writer matches per source
    // ------------------------------
    assign ex_hit_1  = hits(ex_stage.decoded.rd_index, ex_stage.decoded.write_enable,
                            decoded.rs1_index, decoded.read_enable_1);
    assign ex_hit_2  = hits(ex_stage.decoded.rd_index, ex_stage.decoded.write_enable,
                            decoded.rs2_index, decoded.read_enable_2);
    assign mem_hit_1 = hits(mem_stage.rd_index, mem_stage.write_enable,
                            decoded.rs1_index, decoded.read_enable_1);
    assign mem_hit_2 = hits(mem_stage.rd_index, mem_stage.write_enable,
                            decoded.rs2_index, decoded.read_enable_2);
    assign wb_hit_1  = hits(wb_stage.rd_index, wb_stage.write_enable,
                            decoded.rs1_index, decoded.read_enable_1);
    assign wb_hit_2  = hits(wb_stage.rd_index, wb_stage.write_enable,
                            decoded.rs2_index, decoded.read_enable_2);

    // Youngest writer first
    assign rs1_value = ex_hit_1  ? ex_result :
                       mem_hit_1 ? mem_value :
                       wb_hit_1  ? wb_stage.write_data : file_data_1;
    assign rs2_value = ex_hit_2  ? ex_result :
                       mem_hit_2 ? mem_value :
                       wb_hit_2  ? wb_stage.write_data : file_data_2;

    // Load data only exists one stage later
    assign stall = ex_stage.decoded.is_load && (ex_hit_1 || ex_hit_2);

endmodule

// ==== register_file.sv ====
module register_file
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_index_t read_index_1,
    input  reg_index_t read_index_2,
    output word_t      read_data_1,
    output word_t      read_data_2,
    input  logic       write_enable,
    input  reg_index_t write_index,
    input  word_t      write_data
);

    // x0 has no storage
    word_t registers [1:REG_COUNT-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < REG_COUNT; i++)
                registers[i] <= '0;
        end
        else if (write_enable && write_index != '0)
            registers[write_index] <= write_data;
    end

    // Same-cycle write and read is covered by the writeback forward
    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

    // Decoder drops rd = x0 writes, so none should reach the file
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        !(write_enable && write_index == '0))
        else $error("write to x0 reached register file");

endmodule

// ==== tb_core.sv ====
module tb_core
    import core_pkg::*;
();

    localparam int IMEM_DEPTH     = 256;
    localparam int DMEM_DEPTH     = 1024;
    localparam int GOLDEN_DEPTH   = 512;
    localparam     GOLDEN_FILE    = "core_golden.txt";
    localparam int PROGRAM_BASE   = 'h010;
    localparam int SEED_BASE      = 'h0E0;
    localparam int EXPECT_BASE    = 'h100;
    localparam int MARKER_TIMEOUT = 2000;
    localparam int IMEM_MSB       = $clog2(IMEM_DEPTH) + 1;
    localparam int DMEM_MSB       = $clog2(DMEM_DEPTH) + 1;

    logic  clk;
    logic  reset;
    word_t imem_addr;
    word_t imem_data;
    logic  dmem_enable;
    logic  dmem_write;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;

    word_t golden [0:GOLDEN_DEPTH-1];
    word_t imem   [0:IMEM_DEPTH-1];
    word_t dmem   [0:DMEM_DEPTH-1];

    int    program_count;
    int    seed_count;
    int    store_count;
    int    store_index;
    int    value_errors;
    int    other_errors;
    logic  marker_seen;
    word_t marker_addr;

    core_top dut (
        .clk         (clk),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .dmem_enable (dmem_enable),
        .dmem_write  (dmem_write),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_rdata  (dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Memory models
    // ------------------------------
    assign imem_data  = imem[imem_addr[IMEM_MSB:2]];
    assign dmem_rdata = dmem[dmem_addr[DMEM_MSB:2]];

    always @(posedge clk)
    begin
        if (!reset && dmem_enable && dmem_write)
            dmem[dmem_addr[DMEM_MSB:2]] <= dmem_wdata;
    end

    // Header words give the section sizes
    task automatic load_golden();
        $readmemh(GOLDEN_FILE, golden);
        program_count = golden[0];
        seed_count    = golden[1];
        store_count   = golden[2];
        // Unused words are OP-IMM with rd x0, so they decode as NOPs
        for (int k = 0; k < IMEM_DEPTH; k++)
            imem[k] = (word_t'(k) << 12) | NOP_WORD;
        for (int k = 0; k < DMEM_DEPTH; k++)
            dmem[k] = 32'hD47A_0000 | word_t'(k);
        assert (program_count > 0 && program_count <= IMEM_DEPTH && store_count > 0)
        else
        begin
            other_errors++;
            $display("Golden file header has unusable section sizes");
        end
        for (int k = 0; k < program_count && k < IMEM_DEPTH; k++)
            imem[k] = golden[PROGRAM_BASE + k];
        for (int k = 0; k < seed_count; k++)
            dmem[golden[SEED_BASE + 2 * k][DMEM_MSB:2]] = golden[SEED_BASE + 2 * k + 1];
        // Last expected store is the end marker
        if (store_count > 0)
            marker_addr = golden[EXPECT_BASE + 2 * (store_count - 1)];
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic compare_store();
        word_t want_addr;
        word_t want_data;
        assert (store_index < store_count)
        else
        begin
            other_errors++;
            $display("Store to %h at %0t comes after the expected sequence ended",
                     dmem_addr, $time);
        end
        if (store_index < store_count)
        begin
            want_addr = golden[EXPECT_BASE + 2 * store_index];
            want_data = golden[EXPECT_BASE + 2 * store_index + 1];
            assert (dmem_addr === want_addr)
            else
            begin
                value_errors++;
                $display("FAILED at %0t: dmem_addr expected %h, got %h",
                         $time, want_addr, dmem_addr);
            end
            assert (dmem_wdata === want_data)
            else
            begin
                value_errors++;
                $display("FAILED at %0t: dmem_wdata expected %h, got %h",
                         $time, want_data, dmem_wdata);
            end
            store_index++;
        end
        if (dmem_addr === marker_addr)
            marker_seen = 1'b1;
    endtask

    task automatic confirm_bus_idle();
        assert (dmem_enable === 1'b0)
        else
        begin
            value_errors++;
            $display("FAILED at %0t: dmem_enable expected 0, got %b", $time, dmem_enable);
        end
    endtask

    task automatic confirm_start_address();
        assert (imem_addr === RESET_ADDRESS)
        else
        begin
            value_errors++;
            $display("FAILED at %0t: imem_addr expected %h, got %h",
                     $time, RESET_ADDRESS, imem_addr);
        end
    endtask

    task automatic wait_for_marker();
        int cycles;
        cycles = 0;
        while (!marker_seen && cycles < MARKER_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        assert (marker_seen)
        else
        begin
            other_errors++;
            $display("Timed out after %0d cycles without seeing the end marker store",
                     MARKER_TIMEOUT);
        end
    endtask

    task automatic count_missing_stores();
        assert (store_index == store_count)
        else
        begin
            other_errors++;
            $display("Only %0d of %0d expected stores reached the data bus",
                     store_index, store_count);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (reset === 1'b0)
        begin
            assert (!(dmem_write && !dmem_enable))
            else
            begin
                other_errors++;
                $display("dmem_write was high without dmem_enable at %0t", $time);
            end
            if (dmem_enable && dmem_write)
                compare_store();
        end
    end

    // ------------------------------
    // Sequence
    // ------------------------------
    initial
    begin
        reset         = 1'b1;
        store_index   = 0;
        value_errors  = 0;
        other_errors  = 0;
        marker_seen   = 1'b0;
        marker_addr   = '0;
        load_golden();

        // Three reset cycles, bus quiet throughout
        repeat (2)
        begin
            @(posedge clk);
            @(negedge clk);
            confirm_bus_idle();
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        confirm_bus_idle();
        confirm_start_address();

        wait_for_marker();
        count_missing_stores();

        $display("Stores checked %0d of %0d, value errors %0d, other errors %0d",
                 store_index, store_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
